/* hdl/flash_spi_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI NOR flash read protocol constants and the cache line type.
// Shared by the line reader, the cache and the testbench flash model.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package flash_spi_pkg;

    // Standard single-line read opcode
    localparam logic [7:0] READ_CMD = 8'h03;

    localparam int CMD_BITS   = 8;
    localparam int ADDR_BITS  = 24;
    localparam int LINE_BYTES = 16;

    // One whole CE# low period, opcode through last data bit
    localparam int FRAME_BITS = CMD_BITS + ADDR_BITS + LINE_BYTES * 8;

    // Flash byte address
    typedef logic [ADDR_BITS-1:0] flash_addr_t;

    // Byte i in SPI arrival order sits in bits 8i+7..8i
    typedef logic [LINE_BYTES*8-1:0] line_t;

endpackage

`default_nettype wire

/* hdl/ahb_cache_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AHB-Lite encodings, cache geometry and the structs passed between
// the cache controller, the line store and the SPI line reader.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package ahb_cache_pkg;

    // HTRANS values that carry a transfer
    localparam logic [1:0] HTRANS_NONSEQ = 2'd2;
    localparam logic [1:0] HTRANS_SEQ    = 2'd3;

    // Direct-mapped geometry over the 24-bit flash address
    localparam int NUM_LINES     = 32;
    localparam int OFFSET_BITS   = 4;
    localparam int INDEX_BITS    = 5;
    localparam int TAG_BITS      = 15;
    localparam int WORD_SEL_BITS = 2;

    // Address-phase signals as seen on the bus
    typedef struct packed {
        logic        sel;
        logic [1:0]  trans;
        logic        write;
        logic        ready;
        logic [31:0] addr;
    } ahb_addr_t;

    // Line fill request, rd is a one-cycle strobe
    typedef struct packed {
        logic                      rd;
        flash_spi_pkg::flash_addr_t addr;
    } fill_req_t;

    // Line fill completion, line valid while done is high
    typedef struct packed {
        logic                 done;
        flash_spi_pkg::line_t line;
    } fill_rsp_t;

    typedef enum logic [1:0] {
        idle,
        wait_fill,
        data
    } cache_state_t;

endpackage

`default_nettype wire

/* hdl/line_cache.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Direct-mapped read-only line store. Hit is looked up from the live
// address, the read word and the fill target from the registered one.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module line_cache (
    input  logic                       clk,
    input  logic                       rst_n,
    input  flash_spi_pkg::flash_addr_t lookup_addr,
    input  flash_spi_pkg::flash_addr_t read_addr,
    input  logic                       wr,
    input  flash_spi_pkg::line_t       line,
    output logic                       hit,
    output logic [31:0]                rdata
);

    flash_spi_pkg::line_t lines [ahb_cache_pkg::NUM_LINES];
    logic [ahb_cache_pkg::TAG_BITS-1:0] tags [ahb_cache_pkg::NUM_LINES];
    logic [ahb_cache_pkg::NUM_LINES-1:0] valid;

    logic [ahb_cache_pkg::INDEX_BITS-1:0]    lookup_idx;
    logic [ahb_cache_pkg::TAG_BITS-1:0]      lookup_tag;
    logic [ahb_cache_pkg::INDEX_BITS-1:0]    read_idx;
    logic [ahb_cache_pkg::TAG_BITS-1:0]      read_tag;
    logic [ahb_cache_pkg::WORD_SEL_BITS-1:0] word_sel;
    flash_spi_pkg::line_t                    sel_line;

    // Tag | index | offset split of the 24-bit address
    assign lookup_idx = lookup_addr[ahb_cache_pkg::OFFSET_BITS +: ahb_cache_pkg::INDEX_BITS];
    assign lookup_tag = lookup_addr[ahb_cache_pkg::OFFSET_BITS + ahb_cache_pkg::INDEX_BITS +:
                                    ahb_cache_pkg::TAG_BITS];

    assign read_idx = read_addr[ahb_cache_pkg::OFFSET_BITS +: ahb_cache_pkg::INDEX_BITS];
    assign read_tag = read_addr[ahb_cache_pkg::OFFSET_BITS + ahb_cache_pkg::INDEX_BITS +:
                                ahb_cache_pkg::TAG_BITS];

    // Word within the line, byte offset bits 1:0 ignored
    assign word_sel = read_addr[2 +: ahb_cache_pkg::WORD_SEL_BITS];

    assign hit = valid[lookup_idx] && (tags[lookup_idx] == lookup_tag);

    // Little-endian word, lowest flash byte in bits 7:0
    assign sel_line = lines[read_idx];
    assign rdata    = sel_line[32*word_sel +: 32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (wr) begin
            valid[read_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            lines[read_idx] <= line;
            tags[read_idx]  <= read_tag;
        end
    end

    // One write per fill, done is a single-cycle strobe
    a_single_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr |=> !wr
    );

endmodule

`default_nettype wire

/* hdl/spi_line_reader.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reads one cache line from SPI NOR flash with the 0x03 command.
// SCK runs at half the clock; rd starts a frame, done ends it.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module spi_line_reader (
    input  logic                     clk,
    input  logic                     rst_n,
    input  ahb_cache_pkg::fill_req_t fill_req,
    input  logic                     din,
    output ahb_cache_pkg::fill_rsp_t fill_rsp,
    output logic                     sck,
    output logic                     ce_n,
    output logic                     dout
);

    typedef enum logic {
        s_idle,
        s_read
    } reader_state_t;

    reader_state_t state;

    logic [$clog2(flash_spi_pkg::FRAME_BITS)-1:0] bit_cnt;
    logic [$clog2(flash_spi_pkg::FRAME_BITS)-1:0] cmd_sel;
    logic [$clog2(flash_spi_pkg::FRAME_BITS)-1:0] addr_sel;
    logic [$clog2(flash_spi_pkg::FRAME_BITS)-1:0] data_sel;
    logic [$clog2(flash_spi_pkg::LINE_BYTES)-1:0] byte_idx;

    flash_spi_pkg::flash_addr_t               saddr;
    logic [flash_spi_pkg::LINE_BYTES-1:0][7:0] line_q;

    logic start;
    logic done;
    logic rise;
    logic in_data;

    assign start = (state == s_idle) && fill_req.rd;

    // sck low now means this edge is a rising SCK edge
    assign rise = (state == s_read) && !sck;

    // Last data bit sampled on the previous rising edge
    assign done = (state == s_read) && sck &&
                  (bit_cnt == ($bits(bit_cnt))'(flash_spi_pkg::FRAME_BITS - 1));

    // Bit positions inside the opcode, address and data fields
    assign cmd_sel  = ($bits(bit_cnt))'(flash_spi_pkg::CMD_BITS - 1) - bit_cnt;
    assign addr_sel = ($bits(bit_cnt))'(flash_spi_pkg::CMD_BITS + flash_spi_pkg::ADDR_BITS - 1)
                      - bit_cnt;
    assign data_sel = bit_cnt - ($bits(bit_cnt))'(flash_spi_pkg::CMD_BITS +
                                                  flash_spi_pkg::ADDR_BITS);
    assign byte_idx = data_sel[3 +: $bits(byte_idx)];
    assign in_data  = bit_cnt >= ($bits(bit_cnt))'(flash_spi_pkg::CMD_BITS +
                                                   flash_spi_pkg::ADDR_BITS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= s_idle;
            ce_n    <= 1'b1;
            sck     <= 1'b0;
            bit_cnt <= '0;
        end else begin
            if (start) begin
                state   <= s_read;
                ce_n    <= 1'b0;
                bit_cnt <= '0;
            end else if (done) begin
                state <= s_idle;
                ce_n  <= 1'b1;
            end else if (state == s_read && sck) begin
                // Falling SCK edge moves to the next bit
                bit_cnt <= bit_cnt + 1'b1;
            end
            sck <= (state == s_read) ? !sck : 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            saddr <= fill_req.addr;
        end
    end

    // MSB first within each byte
    always_ff @(posedge clk) begin
        if (rise && in_data) begin
            line_q[byte_idx] <= {line_q[byte_idx][6:0], din};
        end
    end

    always_comb begin
        if (bit_cnt < ($bits(bit_cnt))'(flash_spi_pkg::CMD_BITS)) begin
            dout = flash_spi_pkg::READ_CMD[cmd_sel[$clog2(flash_spi_pkg::CMD_BITS)-1:0]];
        end else if (!in_data) begin
            dout = saddr[addr_sel[$clog2(flash_spi_pkg::ADDR_BITS)-1:0]];
        end else begin
            dout = 1'b0;
        end
    end

    assign fill_rsp.done = done;
    assign fill_rsp.line = line_q;

    // Controller must wait for done before the next request
    a_rd_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        fill_req.rd |-> ce_n
    );

endmodule

`default_nettype wire

/* hdl/ahb_cache_ctrl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AHB-Lite side of the flash cache. Registers the address phase, drives
// HREADYOUT and requests a line fill from the SPI reader on a miss.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module ahb_cache_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  ahb_cache_pkg::ahb_addr_t bus,
    input  ahb_cache_pkg::fill_rsp_t fill_rsp,
    output logic                     hreadyout,
    output logic [31:0]              hrdata,
    output ahb_cache_pkg::fill_req_t fill_req
);

    ahb_cache_pkg::cache_state_t state;
    ahb_cache_pkg::cache_state_t state_d;

    logic                       active;
    logic                       hit;
    logic                       hready_d;
    logic                       wr_q;
    flash_spi_pkg::flash_addr_t lookup_addr;
    flash_spi_pkg::flash_addr_t read_addr;

    // Only NONSEQ and SEQ carry a transfer
    assign active = bus.sel && bus.ready &&
                    (bus.trans == ahb_cache_pkg::HTRANS_NONSEQ ||
                     bus.trans == ahb_cache_pkg::HTRANS_SEQ);

    assign lookup_addr = bus.addr[flash_spi_pkg::ADDR_BITS-1:0];

    // Address phase capture, held while the data phase is stalled
    always_ff @(posedge clk) begin
        if (bus.ready) begin
            read_addr <= lookup_addr;
        end
    end

    // Delayed done doubles as the cache write strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_q <= 1'b0;
        end else begin
            wr_q <= fill_rsp.done;
        end
    end

    always_comb begin
        state_d  = ahb_cache_pkg::idle;
        hready_d = 1'b1;
        case (state)
            ahb_cache_pkg::wait_fill: begin
                // Line lands in the cache on this edge
                if (wr_q) begin
                    state_d = ahb_cache_pkg::data;
                end else begin
                    state_d  = ahb_cache_pkg::wait_fill;
                    hready_d = 1'b0;
                end
            end
            default: begin
                if (active && hit) begin
                    state_d = ahb_cache_pkg::data;
                end else if (active) begin
                    state_d  = ahb_cache_pkg::wait_fill;
                    hready_d = 1'b0;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ahb_cache_pkg::idle;
            hreadyout <= 1'b1;
        end else begin
            state     <= state_d;
            hreadyout <= hready_d;
        end
    end

    // Miss raises rd in the address phase itself
    assign fill_req.rd = active && !hit;
    assign fill_req.addr = {lookup_addr[flash_spi_pkg::ADDR_BITS-1:ahb_cache_pkg::OFFSET_BITS],
                            {ahb_cache_pkg::OFFSET_BITS{1'b0}}};

    line_cache i_line_cache (
        .clk         (clk),
        .rst_n       (rst_n),
        .lookup_addr (lookup_addr),
        .read_addr   (read_addr),
        .wr          (wr_q),
        .line        (fill_rsp.line),
        .hit         (hit),
        .rdata       (hrdata)
    );

    // HREADY low during a fill keeps new requests out
    a_rd_outside_fill: assert property (
        @(posedge clk) disable iff (!rst_n)
        fill_req.rd |-> (state == ahb_cache_pkg::idle || state == ahb_cache_pkg::data)
    );

    // Line arrives only while the bus is still held in a fill
    a_stall_in_fill: assert property (
        @(posedge clk) disable iff (!rst_n)
        fill_rsp.done |-> (state == ahb_cache_pkg::wait_fill && !hreadyout)
    );

endmodule

`default_nettype wire

/* hdl/ahb_flash_ctrl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read-only AHB-Lite slave in front of a serial SPI NOR flash.
// Word reads hit a small direct-mapped cache or stall for a line fill.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module ahb_flash_ctrl (
    input  logic        clk,
    input  logic        rst_n,

    // AHB-Lite slave
    input  logic        hsel,
    input  logic [31:0] haddr,
    input  logic [1:0]  htrans,
    input  logic        hwrite,
    input  logic        hready,
    output logic        hreadyout,
    output logic [31:0] hrdata,

    // SPI flash pins
    output logic        sck,
    output logic        ce_n,
    output logic        dout,
    input  logic        din
);

    ahb_cache_pkg::ahb_addr_t bus;
    ahb_cache_pkg::fill_req_t fill_req;
    ahb_cache_pkg::fill_rsp_t fill_rsp;

    assign bus = '{
        sel:   hsel,
        trans: htrans,
        write: hwrite,
        ready: hready,
        addr:  haddr
    };

    ahb_cache_ctrl i_cache_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (bus),
        .fill_rsp  (fill_rsp),
        .hreadyout (hreadyout),
        .hrdata    (hrdata),
        .fill_req  (fill_req)
    );

    spi_line_reader i_line_reader (
        .clk      (clk),
        .rst_n    (rst_n),
        .fill_req (fill_req),
        .din      (din),
        .fill_rsp (fill_rsp),
        .sck      (sck),
        .ce_n     (ce_n),
        .dout     (dout)
    );

endmodule

`default_nettype wire

/* tb/spi_flash_model.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Behavioral SPI NOR flash for the testbench. Answers the 0x03 read from
// a 4 KB byte array that the testbench fills, and checks each frame.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module spi_flash_model (
    input  logic        sck,
    input  logic        ce_n,
    input  logic        si,
    output logic        so,
    output int          frames,
    output logic [23:0] last_addr,
    output logic        proto_error
);

    localparam int HDR_BITS = flash_spi_pkg::CMD_BITS + flash_spi_pkg::ADDR_BITS;

    // Byte array, addresses wrap at 4 KB
    logic [7:0]  mem [4096];
    logic [31:0] header;
    logic        in_frame;
    int          bit_cnt;

    initial begin
        so          = 1'b0;
        frames      = 0;
        last_addr   = '0;
        proto_error = 1'b0;
        header      = '0;
        in_frame    = 1'b0;
        bit_cnt     = 0;
    end

    // One process follows CE# and rising SCK through the whole frame
    always @(negedge ce_n or posedge ce_n or posedge sck) begin
        if (ce_n === 1'b0 && sck === 1'b0) begin
            // CE# has just fallen with SCK idle low
            in_frame = 1'b1;
            bit_cnt  = 0;
            header   = '0;
        end else if (ce_n === 1'b0) begin
            // Mode 0, opcode and address come in on rising SCK
            if (in_frame) begin
                if (bit_cnt < HDR_BITS) begin
                    header = {header[30:0], si};
                end
                bit_cnt = bit_cnt + 1;
                if (bit_cnt == HDR_BITS) begin
                    last_addr = header[23:0];
                    if (header[31:24] != 8'h03) begin
                        proto_error = 1'b1;
                        $display("ERROR at %0t ns: flash got opcode 0x%02h instead of a read",
                                 $time, header[31:24]);
                    end
                    if (header[3:0] != 4'h0) begin
                        proto_error = 1'b1;
                        $display("ERROR at %0t ns: flash read address 0x%06h is not line aligned",
                                 $time, header[23:0]);
                    end
                end
            end
        end else if (in_frame) begin
            // CE# high again ends the frame
            in_frame = 1'b0;
            frames   = frames + 1;
            if (bit_cnt != flash_spi_pkg::FRAME_BITS) begin
                proto_error = 1'b1;
                $display("ERROR at %0t ns: flash frame ended after %0d SCK cycles",
                         $time, bit_cnt);
            end
        end
    end

    // Data out after falling SCK, MSB of each byte first
    always @(negedge sck) begin
        logic [11:0] byte_addr;
        int          d;
        if (in_frame && bit_cnt >= HDR_BITS && bit_cnt < flash_spi_pkg::FRAME_BITS) begin
            d = bit_cnt - HDR_BITS;
            byte_addr = last_addr[11:0] + 12'(d / 8);
            so <= mem[byte_addr][3'(7 - d % 8)];
        end
    end

endmodule

`default_nettype wire

/* tb/tb_ahb_flash_ctrl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the AHB-Lite flash cache. Directed and random word reads
// against a byte-array model and a mirror of the cache tags.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_ahb_flash_ctrl;

    localparam int CLK_NS       = 20;
    localparam int RANDOM_READS = 200;
    localparam int NUM_READS    = RANDOM_READS + 6;
    localparam int WATCHDOG_NS  = NUM_READS * (2 * flash_spi_pkg::FRAME_BITS + 20) * CLK_NS;

    logic        clk;
    logic        rst_n;
    logic        hsel;
    logic [31:0] haddr;
    logic [1:0]  htrans;
    logic        hwrite;
    logic        hready;
    logic        hreadyout;
    logic [31:0] hrdata;
    logic        sck;
    logic        ce_n;
    logic        dout;
    logic        din;
    int          frames;
    logic [23:0] frame_addr;
    logic        proto_error;

    logic [15:0] lfsr;
    logic [7:0]  ref_mem [4096];
    logic [ahb_cache_pkg::TAG_BITS-1:0]  mirror_tag [ahb_cache_pkg::NUM_LINES];
    logic [ahb_cache_pkg::NUM_LINES-1:0] mirror_valid;

    int errors;
    int checks;
    int tests_passed;
    int tests_failed;

    // Single slave, so HREADY is the slave's own HREADYOUT
    assign hready = hreadyout;

    ahb_flash_ctrl i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .hsel      (hsel),
        .haddr     (haddr),
        .htrans    (htrans),
        .hwrite    (hwrite),
        .hready    (hready),
        .hreadyout (hreadyout),
        .hrdata    (hrdata),
        .sck       (sck),
        .ce_n      (ce_n),
        .dout      (dout),
        .din       (din)
    );

    spi_flash_model i_flash (
        .sck         (sck),
        .ce_n        (ce_n),
        .si          (dout),
        .so          (din),
        .frames      (frames),
        .last_addr   (frame_addr),
        .proto_error (proto_error)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    // Little-endian word, byte A in bits 7:0
    function automatic logic [31:0] model_word(input logic [23:0] addr);
        logic [31:0] w;
        logic [11:0] a;
        for (int k = 0; k < 4; k++) begin
            a = addr[11:0] + 12'(k);
            w[8*k +: 8] = ref_mem[a];
        end
        return w;
    endfunction

    // Tag is bits 23:9, index bits 8:4; a miss installs the new tag
    function automatic logic predict_hit(input logic [23:0] addr);
        logic [ahb_cache_pkg::INDEX_BITS-1:0] idx;
        logic [ahb_cache_pkg::TAG_BITS-1:0]   tag;
        idx = addr[8:4];
        tag = addr[23:9];
        if (mirror_valid[idx] && mirror_tag[idx] == tag) begin
            return 1'b1;
        end
        mirror_valid[idx] = 1'b1;
        mirror_tag[idx]   = tag;
        return 1'b0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    task automatic finish_test(input string name, input int errors_at_start);
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d error(s)", name, errors - errors_at_start);
        end
    endtask

    // One NONSEQ word read, data taken mid-cycle once HREADYOUT is high
    task automatic read_word(input logic [23:0] addr, output logic [31:0] data,
                             output int waits);
        @(posedge clk);
        #2;
        hsel   = 1'b1;
        htrans = ahb_cache_pkg::HTRANS_NONSEQ;
        haddr  = {8'h00, addr};
        @(posedge clk);
        #2;
        hsel   = 1'b0;
        htrans = 2'b00;
        waits  = 0;
        @(negedge clk);
        while (!hreadyout) begin
            waits++;
            @(negedge clk);
        end
        data = hrdata;
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] r;
        logic [23:0] addr;
        logic        hit;
        int          waits;
        int          err0;
        int          f0;
        int          misses;
        int          gap;

        rst_n        = 1'b0;
        hsel         = 1'b0;
        haddr        = '0;
        htrans       = 2'b00;
        hwrite       = 1'b0;
        lfsr         = 16'd83;
        mirror_valid = '0;
        errors       = 0;
        checks       = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int i = 0; i < 4096; i++) begin
            ref_mem[12'(i)]         = 8'(rand_bits(8));
            i_flash.mem[12'(i)]     = ref_mem[12'(i)];
        end
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        err0 = errors;
        @(negedge clk);
        check_value("hreadyout", 32'd1, 32'(hreadyout));
        check_value("ce_n", 32'd1, 32'(ce_n));
        check_value("sck", 32'd0, 32'(sck));
        finish_test("1 reset state", err0);

        // Cold cache, first read must fetch its line
        err0 = errors;
        f0   = frames;
        addr = 24'h000124;
        hit  = predict_hit(addr);
        read_word(addr, data, waits);
        check_value("hrdata", model_word(addr), data);
        if (waits == 0) begin
            report_error("first read completed without wait states");
        end
        check_value("frames", 32'(f0 + 1), 32'(frames));
        check_value("frame_addr", 32'h000120, 32'(frame_addr));
        finish_test("2 first read miss", err0);

        err0 = errors;
        f0   = frames;
        addr = 24'h00012c;
        hit  = predict_hit(addr);
        read_word(addr, data, waits);
        check_value("hrdata", model_word(addr), data);
        check_value("wait states", 32'd0, 32'(waits));
        check_value("frames", 32'(f0), 32'(frames));
        finish_test("3 same line hit", err0);

        // Same index 4, tags differ, so each read evicts the other
        err0 = errors;
        for (int n = 0; n < 4; n++) begin
            addr = n[0] ? 24'h001244 : 24'h000048;
            f0   = frames;
            hit  = predict_hit(addr);
            read_word(addr, data, waits);
            check_value("hrdata", model_word(addr), data);
            check_value("frames", 32'(f0 + 1), 32'(frames));
            check_value("frame_addr", 32'({addr[23:4], 4'h0}), 32'(frame_addr));
        end
        finish_test("4 index conflict", err0);

        err0   = errors;
        f0     = frames;
        misses = 0;
        for (int n = 0; n < RANDOM_READS; n++) begin
            r    = rand_bits(9);
            addr = {13'h0000, r[8:0], 2'b00};
            gap  = int'(rand_bits(2));
            repeat (gap) @(posedge clk);
            hit = predict_hit(addr);
            read_word(addr, data, waits);
            check_value("hrdata", model_word(addr), data);
            if (hit && waits != 0) begin
                report_error($sformatf("predicted hit at 0x%06h took %0d wait states",
                                       addr, waits));
            end
            if (!hit) begin
                misses++;
            end
        end
        check_value("frames", 32'(misses), 32'(frames - f0));
        if (proto_error) begin
            report_error("flash model saw a malformed read frame");
        end
        finish_test("5 random reads", err0);

        $display("tests passed: %0d, tests failed: %0d, checks: %0d, errors: %0d",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Every read budgeted as a full line fill
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: reads still pending after %0d ns", WATCHDOG_NS);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
hdl/flash_spi_pkg.sv
hdl/ahb_cache_pkg.sv
hdl/line_cache.sv
hdl/spi_line_reader.sv
hdl/ahb_cache_ctrl.sv
hdl/ahb_flash_ctrl.sv
tb/spi_flash_model.sv
tb/tb_ahb_flash_ctrl.sv

/* Makefile */
# Verilator build and run of the AHB-Lite flash cache testbench

VERILATOR ?= verilator
TOP       ?= tb_ahb_flash_ctrl
FLAGS     ?= --binary --assert --timescale 1ns/1ps
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f
PASS_MSG  := === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR, TOP, FLAGS, OBJ_DIR, FILELIST"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
